// File: logic/axil_sub_pkg.sv
package axil_sub_pkg;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axi_resp_e;

    // Word indices from address bits 3:2
    localparam logic [1:0] REG_A    = 2'd0;
    localparam logic [1:0] REG_B    = 2'd1;
    localparam logic [1:0] REG_RES  = 2'd2;
    localparam logic [1:0] REG_DONE = 2'd3;

    typedef struct packed {
        logic       valid;
        logic       write;
        logic [1:0] addr;
        logic [7:0] wdata;
        logic       bad_addr;
    } bank_req_t;

    // Done is the registered grant pulse
    typedef struct packed {
        logic        done;
        logic [31:0] rdata;
        axi_resp_e   resp;
    } bank_rsp_t;

    typedef enum logic [2:0] {
        W_IDLE,
        W_ADDR,
        W_DATA,
        W_BANK,
        W_RESP
    } write_state_e;

    typedef enum logic [1:0] {
        R_IDLE,
        R_BANK,
        R_DATA
    } read_state_e;

    // Outside the 16-byte window or not word aligned
    function automatic logic addr_bad(input logic [31:0] addr);
        return (addr[31:4] != 28'h0) || (addr[1:0] != 2'b00);
    endfunction

endpackage

// File: logic/axil_write_engine.sv
`timescale 1ns/1ps

module axil_write_engine (
    input  logic                    ACLK,
    input  logic                    ARESETn,
    input  logic [31:0]             AWADDR,
    input  logic                    AWVALID,
    output logic                    AWREADY,
    input  logic [31:0]             WDATA,
    // Only the low byte is stored
    input  logic [3:0]              WSTRB,
    input  logic                    WVALID,
    output logic                    WREADY,
    output logic [1:0]              BRESP,
    output logic                    BVALID,
    input  logic                    BREADY,
    output axil_sub_pkg::bank_req_t wr_req,
    input  axil_sub_pkg::bank_rsp_t wr_rsp
);
    import axil_sub_pkg::*;

    write_state_e state;
    write_state_e state_next;
    logic         aw_fire;
    logic         w_fire;
    logic         req_valid;
    logic [1:0]   req_addr;
    logic         req_bad;
    logic [7:0]   req_wdata;

    assign aw_fire = (state == W_IDLE) && AWVALID && AWREADY;
    assign w_fire  = (state == W_DATA) && WVALID && WREADY;

    always_comb begin
        case (state)
            W_IDLE:  state_next = aw_fire ? W_ADDR : W_IDLE;
            W_ADDR:  state_next = W_DATA;
            W_DATA:  state_next = w_fire ? W_BANK : W_DATA;
            W_BANK:  state_next = wr_rsp.done ? W_RESP : W_BANK;
            W_RESP:  state_next = (BVALID && BREADY) ? W_IDLE : W_RESP;
            default: state_next = W_IDLE;
        endcase
    end

    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            state     <= W_IDLE;
            AWREADY   <= 1'b1;
            WREADY    <= 1'b0;
            BVALID    <= 1'b0;
            BRESP     <= OKAY;
            req_valid <= 1'b0;
        end else begin
            state <= state_next;
            case (state)
                W_IDLE: begin
                    if (aw_fire) begin
                        AWREADY <= 1'b0;
                    end
                end
                W_ADDR: begin
                    WREADY <= 1'b1;
                end
                W_DATA: begin
                    if (w_fire) begin
                        WREADY    <= 1'b0;
                        req_valid <= 1'b1;
                    end
                end
                W_BANK: begin
                    // Hold the request until the arbiter answers
                    if (wr_rsp.done) begin
                        req_valid <= 1'b0;
                        BVALID    <= 1'b1;
                        BRESP     <= wr_rsp.resp;
                    end
                end
                W_RESP: begin
                    if (BREADY) begin
                        BVALID  <= 1'b0;
                        AWREADY <= 1'b1;
                    end
                end
                default: begin
                    AWREADY <= 1'b1;
                end
            endcase
        end
    end

    always_ff @(posedge ACLK) begin
        if (aw_fire) begin
            req_addr <= AWADDR[3:2];
            req_bad  <= addr_bad(AWADDR);
        end
        if (w_fire) begin
            req_wdata <= WDATA[7:0];
        end
    end

    assign wr_req = '{
        valid:    req_valid,
        write:    1'b1,
        addr:     req_addr,
        wdata:    req_wdata,
        bad_addr: req_bad
    };

endmodule

// File: logic/axil_read_engine.sv
`timescale 1ns/1ps

module axil_read_engine (
    input  logic                    ACLK,
    input  logic                    ARESETn,
    input  logic [31:0]             ARADDR,
    input  logic                    ARVALID,
    output logic                    ARREADY,
    output logic [31:0]             RDATA,
    output logic [1:0]              RRESP,
    output logic                    RVALID,
    input  logic                    RREADY,
    output axil_sub_pkg::bank_req_t rd_req,
    input  axil_sub_pkg::bank_rsp_t rd_rsp
);
    import axil_sub_pkg::*;

    read_state_e state;
    read_state_e state_next;
    logic        ar_fire;
    logic        req_valid;
    logic [1:0]  req_addr;
    logic        req_bad;

    assign ar_fire = (state == R_IDLE) && ARVALID && ARREADY;

    always_comb begin
        case (state)
            R_IDLE:  state_next = ar_fire ? R_BANK : R_IDLE;
            R_BANK:  state_next = rd_rsp.done ? R_DATA : R_BANK;
            R_DATA:  state_next = (RVALID && RREADY) ? R_IDLE : R_DATA;
            default: state_next = R_IDLE;
        endcase
    end

    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            state     <= R_IDLE;
            ARREADY   <= 1'b1;
            RVALID    <= 1'b0;
            RRESP     <= OKAY;
            req_valid <= 1'b0;
        end else begin
            state <= state_next;
            case (state)
                R_IDLE: begin
                    if (ar_fire) begin
                        ARREADY   <= 1'b0;
                        req_valid <= 1'b1;
                    end
                end
                R_BANK: begin
                    if (rd_rsp.done) begin
                        req_valid <= 1'b0;
                        RVALID    <= 1'b1;
                        RRESP     <= rd_rsp.resp;
                    end
                end
                R_DATA: begin
                    if (RREADY) begin
                        RVALID  <= 1'b0;
                        ARREADY <= 1'b1;
                    end
                end
                default: begin
                    ARREADY <= 1'b1;
                end
            endcase
        end
    end

    // Address and read data only change between transfers
    always_ff @(posedge ACLK) begin
        if (ar_fire) begin
            req_addr <= ARADDR[3:2];
            req_bad  <= addr_bad(ARADDR);
        end
        if (state == R_BANK && rd_rsp.done) begin
            RDATA <= rd_rsp.rdata;
        end
    end

    assign rd_req = '{
        valid:    req_valid,
        write:    1'b0,
        addr:     req_addr,
        wdata:    8'h00,
        bad_addr: req_bad
    };

endmodule

// File: logic/reg_bank_arbiter.sv
`timescale 1ns/1ps

module reg_bank_arbiter (
    input  logic                    ACLK,
    input  logic                    ARESETn,
    input  axil_sub_pkg::bank_req_t wr_req,
    input  axil_sub_pkg::bank_req_t rd_req,
    output axil_sub_pkg::bank_rsp_t wr_rsp,
    output axil_sub_pkg::bank_rsp_t rd_rsp,
    output logic [7:0]              op_a,
    output logic [7:0]              op_b,
    output logic                    op_load,
    input  logic [7:0]              result,
    input  logic                    done_flag
);
    import axil_sub_pkg::*;

    logic        last_wr;
    logic        wr_elig;
    logic        rd_elig;
    logic        grant_wr;
    logic        grant_rd;
    logic        acc_err;
    logic        wr_hit;
    logic [31:0] rd_word;
    axi_resp_e   acc_resp;
    bank_req_t   sel;

    // A request whose done pulse is out is already served
    assign wr_elig = wr_req.valid && !wr_rsp.done;
    assign rd_elig = rd_req.valid && !rd_rsp.done;

    // On a tie the side not served last wins
    assign grant_wr = wr_elig && (!rd_elig || !last_wr);
    assign grant_rd = rd_elig && !grant_wr;
    assign sel      = grant_wr ? wr_req : rd_req;

    always_comb begin
        rd_word = 32'h0;
        if (!sel.bad_addr) begin
            case (sel.addr)
                REG_A:    rd_word = {24'h0, op_a};
                REG_B:    rd_word = {24'h0, op_b};
                REG_RES:  rd_word = {24'h0, result};
                REG_DONE: rd_word = {31'h0, done_flag};
                default:  rd_word = 32'h0;
            endcase
        end
        // Result and done flag are read only
        acc_err  = sel.bad_addr ||
                   (sel.write && (sel.addr == REG_RES || sel.addr == REG_DONE));
        acc_resp = acc_err ? SLVERR : OKAY;
        wr_hit   = (grant_wr || grant_rd) && sel.write && !acc_err;
    end

    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            last_wr      <= 1'b0;
            op_a         <= 8'h00;
            op_b         <= 8'h00;
            op_load      <= 1'b0;
            wr_rsp.done  <= 1'b0;
            wr_rsp.rdata <= 32'h0;
            wr_rsp.resp  <= OKAY;
            rd_rsp.done  <= 1'b0;
            rd_rsp.rdata <= 32'h0;
            rd_rsp.resp  <= OKAY;
        end else begin
            wr_rsp.done <= grant_wr;
            rd_rsp.done <= grant_rd;
            op_load     <= wr_hit;
            if (grant_wr || grant_rd) begin
                last_wr <= grant_wr;
            end
            if (grant_wr) begin
                wr_rsp.rdata <= rd_word;
                wr_rsp.resp  <= acc_resp;
            end
            if (grant_rd) begin
                rd_rsp.rdata <= rd_word;
                rd_rsp.resp  <= acc_resp;
            end
            if (wr_hit) begin
                if (sel.addr == REG_A) begin
                    op_a <= sel.wdata;
                end else begin
                    op_b <= sel.wdata;
                end
            end
        end
    end

endmodule

// File: logic/sub_pipeline.sv
`timescale 1ns/1ps

module sub_pipeline (
    input  logic       ACLK,
    input  logic       ARESETn,
    input  logic [7:0] op_a,
    input  logic [7:0] op_b,
    input  logic       op_load,
    output logic [7:0] result,
    output logic       done_flag
);

    logic [7:0] s1_a;
    logic [7:0] s1_b;
    logic [7:0] s2_diff;
    logic       s1_valid;
    logic       s2_valid;
    logic       s3_valid;
    logic [2:0] in_flight;
    logic [2:0] in_flight_next;

    // One token enters per load, one leaves after the output stage
    assign in_flight_next = in_flight + {2'b00, op_load} - {2'b00, s3_valid};

    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            s1_valid  <= 1'b0;
            s2_valid  <= 1'b0;
            s3_valid  <= 1'b0;
            result    <= 8'h00;
            in_flight <= 3'd0;
            done_flag <= 1'b0;
        end else begin
            s1_valid  <= op_load;
            s2_valid  <= s1_valid;
            s3_valid  <= s2_valid;
            in_flight <= in_flight_next;
            if (s2_valid) begin
                result <= s2_diff;
            end
            if (op_load) begin
                done_flag <= 1'b0;
            end else if (s3_valid && in_flight_next == 3'd0) begin
                done_flag <= 1'b1;
            end
        end
    end

    always_ff @(posedge ACLK) begin
        if (op_load) begin
            s1_a <= op_a;
            s1_b <= op_b;
        end
        // Wraps modulo 256
        if (s1_valid) begin
            s2_diff <= s1_a - s1_b;
        end
    end

endmodule

// File: logic/axil_sub_top.sv
`timescale 1ns/1ps

module axil_sub_top (
    input  logic        ACLK,
    input  logic        ARESETn,
    input  logic [31:0] AWADDR,
    input  logic        AWVALID,
    output logic        AWREADY,
    input  logic [31:0] WDATA,
    input  logic [3:0]  WSTRB,
    input  logic        WVALID,
    output logic        WREADY,
    output logic [1:0]  BRESP,
    output logic        BVALID,
    input  logic        BREADY,
    input  logic [31:0] ARADDR,
    input  logic        ARVALID,
    output logic        ARREADY,
    output logic [31:0] RDATA,
    output logic [1:0]  RRESP,
    output logic        RVALID,
    input  logic        RREADY
);
    import axil_sub_pkg::*;

    bank_req_t  wr_req;
    bank_req_t  rd_req;
    bank_rsp_t  wr_rsp;
    bank_rsp_t  rd_rsp;
    logic [7:0] op_a;
    logic [7:0] op_b;
    logic       op_load;
    logic [7:0] result;
    logic       done_flag;

    axil_write_engine u_write_engine (
        .ACLK    (ACLK),
        .ARESETn (ARESETn),
        .AWADDR  (AWADDR),
        .AWVALID (AWVALID),
        .AWREADY (AWREADY),
        .WDATA   (WDATA),
        .WSTRB   (WSTRB),
        .WVALID  (WVALID),
        .WREADY  (WREADY),
        .BRESP   (BRESP),
        .BVALID  (BVALID),
        .BREADY  (BREADY),
        .wr_req  (wr_req),
        .wr_rsp  (wr_rsp)
    );

    axil_read_engine u_read_engine (
        .ACLK    (ACLK),
        .ARESETn (ARESETn),
        .ARADDR  (ARADDR),
        .ARVALID (ARVALID),
        .ARREADY (ARREADY),
        .RDATA   (RDATA),
        .RRESP   (RRESP),
        .RVALID  (RVALID),
        .RREADY  (RREADY),
        .rd_req  (rd_req),
        .rd_rsp  (rd_rsp)
    );

    reg_bank_arbiter u_bank (
        .ACLK      (ACLK),
        .ARESETn   (ARESETn),
        .wr_req    (wr_req),
        .rd_req    (rd_req),
        .wr_rsp    (wr_rsp),
        .rd_rsp    (rd_rsp),
        .op_a      (op_a),
        .op_b      (op_b),
        .op_load   (op_load),
        .result    (result),
        .done_flag (done_flag)
    );

    sub_pipeline u_pipeline (
        .ACLK      (ACLK),
        .ARESETn   (ARESETn),
        .op_a      (op_a),
        .op_b      (op_b),
        .op_load   (op_load),
        .result    (result),
        .done_flag (done_flag)
    );

endmodule

// File: verif/axil_sub_sva.sv
`timescale 1ns/1ps

module axil_sub_sva (
    input logic                       ACLK,
    input logic                       ARESETn,
    input logic                       AWREADY,
    input logic                       WREADY,
    input logic                       BVALID,
    input logic                       BREADY,
    input logic                       RVALID,
    input logic                       RREADY,
    input logic [31:0]                RDATA,
    input axil_sub_pkg::write_state_e wr_state
);
    import axil_sub_pkg::*;

    a_bvalid_hold: assert property (
        @(posedge ACLK) disable iff (!ARESETn)
        BVALID && !BREADY |=> BVALID
    ) else $error("BVALID dropped before BREADY");

    // Read data must not move while the master stalls
    a_rvalid_hold: assert property (
        @(posedge ACLK) disable iff (!ARESETn)
        RVALID && !RREADY |=> RVALID && $stable(RDATA)
    ) else $error("RVALID or RDATA changed before RREADY");

    a_aw_b_excl: assert property (
        @(posedge ACLK) disable iff (!ARESETn)
        !(AWREADY && BVALID)
    ) else $error("AWREADY and BVALID high together");

    a_wready_state: assert property (
        @(posedge ACLK) disable iff (!ARESETn)
        WREADY |-> wr_state == W_DATA
    ) else $error("WREADY high outside W_DATA");

endmodule

bind axil_sub_top axil_sub_sva u_sva (
    .ACLK     (ACLK),
    .ARESETn  (ARESETn),
    .AWREADY  (AWREADY),
    .WREADY   (WREADY),
    .BVALID   (BVALID),
    .BREADY   (BREADY),
    .RVALID   (RVALID),
    .RREADY   (RREADY),
    .RDATA    (RDATA),
    .wr_state (u_write_engine.state)
);

// File: verif/tb_axil_sub.sv
`timescale 1ns/1ps

module tb_axil_sub;
    import axil_sub_pkg::*;

    localparam int HS_LIMIT = 64;

    logic        ACLK;
    logic        ARESETn;
    logic [31:0] AWADDR;
    logic        AWVALID;
    logic        AWREADY;
    logic [31:0] WDATA;
    logic [3:0]  WSTRB;
    logic        WVALID;
    logic        WREADY;
    logic [1:0]  BRESP;
    logic        BVALID;
    logic        BREADY;
    logic [31:0] ARADDR;
    logic        ARVALID;
    logic        ARREADY;
    logic [31:0] RDATA;
    logic [1:0]  RRESP;
    logic        RVALID;
    logic        RREADY;

    logic [7:0]  cmd_q[$];
    logic [31:0] addr_q[$];
    logic [31:0] data_q[$];
    logic [1:0]  resp_q[$];

    int   mismatches = 0;
    int   failures = 0;
    int   cycle_count = 0;
    int   cycle_limit = 200;
    int   writes_done = 0;
    int   reads_done = 0;
    int   b_seen = 0;
    int   r_seen = 0;
    logic w_busy = 1'b0;
    logic r_busy = 1'b0;
    logic aborted = 1'b0;

    axil_sub_top UUT (.*);

    initial ACLK = 1'b0;
    always #5 ACLK = ~ACLK;

    always @(posedge ACLK) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("Run stopped after %0d cycles without finishing", cycle_limit);
            $display("Simulation failed");
            $finish;
        end
    end

    // Responses counted mid-cycle where outputs are settled
    always @(negedge ACLK) begin
        if (ARESETn) begin
            if (BVALID && BREADY) b_seen++;
            if (RVALID && RREADY) r_seen++;
            if (BVALID && !w_busy) begin
                $display("Write response at %0t with no write outstanding", $time);
                failures++;
            end
            if (RVALID && !r_busy) begin
                $display("Read response at %0t with no read outstanding", $time);
                failures++;
            end
        end
    end

    function automatic logic probe(input string name);
        case (name)
            "AWREADY": return AWREADY;
            "WREADY":  return WREADY;
            "BVALID":  return BVALID;
            "ARREADY": return ARREADY;
            default:   return RVALID;
        endcase
    endfunction

    task automatic next_cycle();
        @(posedge ACLK);
        #1;
    endtask

    // Returns at the negedge before the edge that completes the handshake
    task automatic wait_for(input string name);
        int cnt;
        cnt = 0;
        @(negedge ACLK);
        while (!probe(name) && cnt < HS_LIMIT) begin
            @(negedge ACLK);
            cnt++;
        end
        if (!probe(name)) begin
            $display("Timed out at %0t waiting for %s", $time, name);
            failures++;
            aborted = 1'b1;
        end
    endtask

    task automatic do_write(input int idx, input logic fast);
        int skew;
        int aw_skew;
        int w_skew;
        int bp;
        skew    = $urandom % 3;
        bp      = $urandom % 4;
        aw_skew = 0;
        w_skew  = 0;
        if ($urandom % 2 == 0) aw_skew = skew;
        else w_skew = skew;
        w_busy = 1'b1;
        BREADY = fast || (bp == 0);
        fork
            begin
                repeat (aw_skew) next_cycle();
                AWADDR  = addr_q[idx];
                AWVALID = 1'b1;
                wait_for("AWREADY");
                next_cycle();
                AWVALID = 1'b0;
            end
            begin
                repeat (w_skew) next_cycle();
                WDATA  = data_q[idx];
                WSTRB  = 4'hf;
                WVALID = 1'b1;
                wait_for("WREADY");
                next_cycle();
                WVALID = 1'b0;
            end
        join
        if (!aborted) wait_for("BVALID");
        if (aborted) return;
        if (!BREADY) begin
            repeat (bp) next_cycle();
            BREADY = 1'b1;
            @(negedge ACLK);
        end
        if (!BVALID) begin
            $display("BVALID dropped at %0t before BREADY", $time);
            failures++;
        end else if (BRESP !== resp_q[idx]) begin
            $display("Mismatch at %0t: write to 0x%08h gave BRESP %0d, expected %0d",
                     $time, addr_q[idx], BRESP, resp_q[idx]);
            mismatches++;
        end
        next_cycle();
        BREADY = 1'b0;
        w_busy = 1'b0;
        writes_done++;
    endtask

    task automatic do_read(input int idx, input logic fast);
        int bp;
        bp      = $urandom % 4;
        r_busy  = 1'b1;
        RREADY  = fast || (bp == 0);
        ARADDR  = addr_q[idx];
        ARVALID = 1'b1;
        wait_for("ARREADY");
        next_cycle();
        ARVALID = 1'b0;
        if (!aborted) wait_for("RVALID");
        if (aborted) return;
        if (!RREADY) begin
            repeat (bp) next_cycle();
            RREADY = 1'b1;
            @(negedge ACLK);
        end
        if (!RVALID) begin
            $display("RVALID dropped at %0t before RREADY", $time);
            failures++;
        end else if (RDATA !== data_q[idx] || RRESP !== resp_q[idx]) begin
            $display("Mismatch at %0t: read of 0x%08h gave 0x%08h/%0d, expected 0x%08h/%0d",
                     $time, addr_q[idx], RDATA, RRESP, data_q[idx], resp_q[idx]);
            mismatches++;
        end
        next_cycle();
        RREADY = 1'b0;
        r_busy = 1'b0;
        reads_done++;
    endtask

    initial begin
        int          fd;
        int          n;
        int          lines;
        int          count;
        int          i;
        int          seed_val;
        string       line;
        logic [7:0]  c;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] r;
        logic        fast;
        logic        pair;

        seed_val = $urandom(32'hc2fb_e625);
        ARESETn  = 1'b0;
        AWADDR   = 32'h0;
        AWVALID  = 1'b0;
        WDATA    = 32'h0;
        WSTRB    = 4'h0;
        WVALID   = 1'b0;
        BREADY   = 1'b0;
        ARADDR   = 32'h0;
        ARVALID  = 1'b0;
        RREADY   = 1'b0;

        lines = 0;
        fd = $fopen("verif/tb_input.txt", "r");
        if (fd == 0) begin
            $display("Could not open verif/tb_input.txt");
            failures++;
        end else begin
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                if (n > 0) begin
                    lines++;
                    n = $sscanf(line, "%c %h %h %h", c, a, d, r);
                    if (n >= 2 && c != "#") begin
                        cmd_q.push_back(c);
                        addr_q.push_back(a);
                        data_q.push_back(d);
                        resp_q.push_back(r[1:0]);
                    end
                end
            end
            $fclose(fd);
        end
        cycle_limit = 60 * lines + 200;
        count = cmd_q.size();

        repeat (8) @(posedge ACLK);
        #1;
        ARESETn = 1'b1;
        @(negedge ACLK);
        if (AWREADY !== 1'b1 || WREADY !== 1'b0 || BVALID !== 1'b0 ||
            ARREADY !== 1'b1 || RVALID !== 1'b0) begin
            $display("Mismatch at %0t: AWREADY WREADY BVALID ARREADY RVALID %b%b%b%b%b, %s",
                     $time, AWREADY, WREADY, BVALID, ARREADY, RVALID, "expected 10010");
            mismatches++;
        end
        next_cycle();

        i = 0;
        while (i < count && !aborted) begin
            if (cmd_q[i] == "D") begin
                repeat (addr_q[i]) next_cycle();
            end else if (cmd_q[i] == "R") begin
                // Done flag read straight after a write goes without stalls
                fast = (i > 0) && (cmd_q[i-1] == "W") && (addr_q[i] == 32'hc);
                do_read(i, fast);
            end else if (cmd_q[i] == "W") begin
                fast = (i + 1 < count) && (cmd_q[i+1] == "R") && (addr_q[i+1] == 32'hc);
                // Read of the other operand overlaps the write
                pair = (i + 1 < count) && (cmd_q[i+1] == "R") &&
                       (addr_q[i] == 32'h0 || addr_q[i] == 32'h4) &&
                       (addr_q[i+1] == 32'h0 || addr_q[i+1] == 32'h4) &&
                       (addr_q[i] != addr_q[i+1]);
                if (pair) begin
                    fork
                        do_write(i, 1'b0);
                        do_read(i + 1, 1'b0);
                    join
                    i++;
                end else begin
                    do_write(i, fast);
                end
            end else begin
                $display("Unknown command in input entry %0d", i);
                failures++;
            end
            i++;
        end

        next_cycle();
        if (b_seen != writes_done || r_seen != reads_done) begin
            $display("Saw %0d write and %0d read responses for %0d writes and %0d reads",
                     b_seen, r_seen, writes_done, reads_done);
            failures++;
        end
        $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: axil_sub.f
logic/axil_sub_pkg.sv
logic/axil_write_engine.sv
logic/axil_read_engine.sv
logic/reg_bank_arbiter.sv
logic/sub_pipeline.sv
logic/axil_sub_top.sv
verif/axil_sub_sva.sv
verif/tb_axil_sub.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, run from the project root

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module tb_axil_sub \
    -f axil_sub.f --Mdir obj_dir -o tb_axil_sub
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_axil_sub > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi

if grep -q "^%Error" "$LOG"; then
    echo "Assertion or runtime errors found in $LOG"
    exit 1
fi
if grep -q "Simulation completed successfully" "$LOG"; then
    exit 0
fi
exit 1

// File: verif/tb_input.txt
# cmd addr data resp: W writes, R reads and checks, D waits addr cycles
# all fields hex, resp 0 is OKAY and 2 is SLVERR
W 00000000 0000000c 0
W 00000004 00000005 0
D 00000008
R 00000008 00000007 0
R 0000000c 00000001 0
R 00000000 0000000c 0
R 00000004 00000005 0
W 00000000 deadbe5a 0
W 00000004 ffffff21 0
R 00000000 0000005a 0
R 00000004 00000021 0
D 00000008
R 00000008 00000039 0
W 00000000 00000003 0
R 0000000c 00000000 0
W 00000004 00000005 0
D 00000008
R 00000008 000000fe 0
R 0000000c 00000001 0
W 00000008 000000aa 2
W 0000000c 00000001 2
W 00000010 00000077 2
W 00000002 00000066 2
R 00000000 00000003 0
R 00000004 00000005 0
R 00000008 000000fe 0
R 00000014 00000000 2
R 00000001 00000000 2
R 0000000c 00000001 0
W 00000004 000000ff 0
W 00000000 00000080 0
R 00000004 000000ff 0
D 00000008
R 00000008 00000081 0
W 00000000 00000000 0
R 0000000c 00000000 0
D 00000008
R 00000008 00000001 0
R 0000000c 00000001 0
W 00000004 00000001 0
R 00000000 00000000 0
D 00000006
R 00000008 000000ff 0
